/* design/trap_defs.svh */
// trap unit macros: register width, mstatus bits, interrupt mask, CSR addresses, cause codes
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

`define XLEN 64

// mstatus interrupt enable bits
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

// mip/mie bits backed by real interrupt lines
`define IRQ_MASK 64'h0000_0000_0000_0888

// machine CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MTVAL   12'h343
`define CSR_MIP     12'h344

// exception codes
`define CAUSE_INST_MISAL 4'd0
`define CAUSE_INST_ACC   4'd1
`define CAUSE_ILG_INST   4'd2
`define CAUSE_BRK_PT     4'd3
`define CAUSE_LOAD_MISAL 4'd4
`define CAUSE_LOAD_ACC   4'd5
`define CAUSE_STOR_MISAL 4'd6
`define CAUSE_STOR_ACC   4'd7
`define CAUSE_ECALL_M    4'd11
`define CAUSE_INST_PAGE  4'd12
`define CAUSE_LOAD_PAGE  4'd13
`define CAUSE_STOR_PAGE  4'd15

// interrupt codes, also the bit positions in mie and mip
`define CAUSE_MSI 4'd3
`define CAUSE_MTI 4'd7
`define CAUSE_MEI 4'd11

`endif

/* design/trap_pkg.sv */
// trap_pkg: fault and interrupt vectors, CSR exchange buses, CSR and timer opcodes
`include "trap_defs.svh"

package trap_pkg;

  // one flag per fault, lowest cause code in the lsb
  typedef struct packed {
    logic stor_page;
    logic load_page;
    logic inst_page;
    logic ecall_m;
    logic stor_acc;
    logic stor_misal;
    logic load_acc;
    logic load_misal;
    logic brk_pt;
    logic ilg_inst;
    logic inst_acc;
    logic inst_misal;
  } excp_vec_t;

  // raw interrupt lines
  typedef struct packed {
    logic ext_irq;
    logic timer_irq;
    logic soft_irq;
  } itrp_vec_t;

  // current CSR values seen by the handler
  typedef struct packed {
    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mie;
    logic [`XLEN-1:0] mip;
  } csr_rd_bus_t;

  // next CSR values from the handler
  typedef struct packed {
    logic [`XLEN-1:0] mip;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mtval;
    logic [`XLEN-1:0] mstatus;
    logic             trap_enter;
    logic             trap_exit;
  } csr_wr_bus_t;

  typedef enum logic [1:0] {
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_op_e;

  typedef enum logic {
    CLINT_MTIMECMP,
    CLINT_MSIP
  } clint_reg_e;

endpackage

/* design/clint_timer.sv */
// clint_timer: free-running mtime, mtimecmp and msip registers, timer and software irq levels
`include "trap_defs.svh"

module clint_timer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clint_we,
  input  trap_pkg::clint_reg_e clint_sel,
  input  logic [`XLEN-1:0]     clint_wdata,
  output logic                 timer_irq,
  output logic                 soft_irq,
  output logic [`XLEN-1:0]     mtime
);
  import trap_pkg::*;

  logic [`XLEN-1:0] mtime_q;
  logic [`XLEN-1:0] mtimecmp_q;
  logic             msip_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // compare starts at all ones so no timer irq until software arms it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else if (clint_we) begin
      case (clint_sel)
        CLINT_MTIMECMP: mtimecmp_q <= clint_wdata;
        CLINT_MSIP:     msip_q     <= clint_wdata[0];
        default: ;
      endcase
    end
  end

  assign timer_irq = (mtime_q >= mtimecmp_q);
  assign soft_irq  = msip_q;
  assign mtime     = mtime_q;

endmodule

/* design/machine_csrs.sv */
// machine_csrs: mstatus, mie, mip, mtvec, mepc, mcause, mtval with software and trap ports
`include "trap_defs.svh"

module machine_csrs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  trap_pkg::itrp_vec_t   itrp_lines,
  input  trap_pkg::csr_wr_bus_t csr_wr,
  input  logic                  csr_en,
  input  trap_pkg::csr_op_e     csr_op,
  input  logic [11:0]           csr_addr,
  input  logic [`XLEN-1:0]      csr_wdata,
  output trap_pkg::csr_rd_bus_t csr_rd,
  output logic [`XLEN-1:0]      csr_rdata
);
  import trap_pkg::*;

  logic [`XLEN-1:0] mstatus_q;
  logic [`XLEN-1:0] mie_q;
  logic [`XLEN-1:0] mip_q;
  logic [`XLEN-1:0] mtvec_q;
  logic [`XLEN-1:0] mepc_q;
  logic [`XLEN-1:0] mcause_q;
  logic [`XLEN-1:0] mtval_q;
  logic [`XLEN-1:0] line_bits;
  logic [`XLEN-1:0] sw_val;
  logic [`XLEN-1:0] mtvec_legal;

  // lines placed at their mip bit positions
  always_comb begin
    line_bits = '0;
    line_bits[`CAUSE_MEI] = itrp_lines.ext_irq;
    line_bits[`CAUSE_MTI] = itrp_lines.timer_irq;
    line_bits[`CAUSE_MSI] = itrp_lines.soft_irq;
  end

  // read mux
  always_comb begin
    case (csr_addr)
      `CSR_MSTATUS: csr_rdata = mstatus_q;
      `CSR_MIE:     csr_rdata = mie_q;
      `CSR_MIP:     csr_rdata = mip_q;
      `CSR_MTVEC:   csr_rdata = mtvec_q;
      `CSR_MEPC:    csr_rdata = mepc_q;
      `CSR_MCAUSE:  csr_rdata = mcause_q;
      `CSR_MTVAL:   csr_rdata = mtval_q;
      default:      csr_rdata = '0;
    endcase
  end

  // read-modify-write value
  always_comb begin
    case (csr_op)
      CSR_WRITE: sw_val = csr_wdata;
      CSR_SET:   sw_val = csr_rdata | csr_wdata;
      CSR_CLEAR: sw_val = csr_rdata & ~csr_wdata;
      default:   sw_val = csr_rdata;
    endcase
  end

  // reserved modes fall back to direct
  assign mtvec_legal = {sw_val[`XLEN-1:2], (sw_val[1:0] > 2'd1) ? 2'b00 : sw_val[1:0]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mie_q     <= '0;
      mip_q     <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtval_q   <= '0;
    end else begin
      mip_q <= line_bits | (csr_wr.mip & ~`IRQ_MASK);

      if (csr_en) begin
        case (csr_addr)
          `CSR_MSTATUS: mstatus_q <= sw_val;
          `CSR_MIE:     mie_q     <= sw_val & `IRQ_MASK;
          `CSR_MTVEC:   mtvec_q   <= mtvec_legal;
          `CSR_MEPC:    mepc_q    <= sw_val;
          `CSR_MCAUSE:  mcause_q  <= sw_val;
          `CSR_MTVAL:   mtval_q   <= sw_val;
          default: ;
        endcase
      end

      // trap update last so it beats a same-cycle software write
      if (csr_wr.trap_enter) begin
        mcause_q  <= csr_wr.mcause;
        mepc_q    <= csr_wr.mepc;
        mtval_q   <= csr_wr.mtval;
        mstatus_q <= csr_wr.mstatus;
      end else if (csr_wr.trap_exit) begin
        mstatus_q <= csr_wr.mstatus;
      end
    end
  end

  assign csr_rd.mstatus = mstatus_q;
  assign csr_rd.mtvec   = mtvec_q;
  assign csr_rd.mepc    = mepc_q;
  assign csr_rd.mie     = mie_q;
  assign csr_rd.mip     = mip_q;

  mtvec_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
    mtvec_q[1:0] <= 2'd1);

endmodule

/* design/trap_handler.sv */
// trap_handler: cause priority decode, trap CSR write values, trap entry and mret redirect
`include "trap_defs.svh"

module trap_handler (
  input  trap_pkg::excp_vec_t   excp_info,
  input  logic [`XLEN-1:0]      now_pc,
  input  logic [31:0]           now_inst,
  input  logic [`XLEN-1:0]      mem_addr,
  input  logic                  excp_exit,
  input  trap_pkg::csr_rd_bus_t csr_rd,
  output trap_pkg::csr_wr_bus_t csr_wr,
  output logic                  itrp_valid,
  output logic                  excp_jmp_ena,
  output logic [`XLEN-1:0]      excp_jmp_pc
);
  import trap_pkg::*;

  logic             glb_ie;
  logic             take_ext;
  logic             take_soft;
  logic             take_timer;
  logic             excp_any;
  logic             trap_enter;
  logic [3:0]       itrp_code;
  logic [3:0]       excp_code;
  logic [3:0]       cause_code;
  logic [`XLEN-1:0] tval;
  logic [`XLEN-1:0] mstatus_nxt;
  logic [1:0]       tvec_mode;
  logic [`XLEN-1:0] tvec_base;
  logic [`XLEN-1:0] enter_pc;

  // interrupt needs global enable, its mie bit and its mip bit
  assign glb_ie     = csr_rd.mstatus[`MSTATUS_MIE];
  assign take_ext   = glb_ie & csr_rd.mie[`CAUSE_MEI] & csr_rd.mip[`CAUSE_MEI];
  assign take_soft  = glb_ie & csr_rd.mie[`CAUSE_MSI] & csr_rd.mip[`CAUSE_MSI];
  assign take_timer = glb_ie & csr_rd.mie[`CAUSE_MTI] & csr_rd.mip[`CAUSE_MTI];
  assign itrp_valid = take_ext | take_soft | take_timer;

  assign excp_any   = |excp_info;
  assign trap_enter = itrp_valid | excp_any;

  // external over software over timer
  assign itrp_code = take_ext  ? `CAUSE_MEI :
                     take_soft ? `CAUSE_MSI : `CAUSE_MTI;

  // lowest exception code wins
  always_comb begin
    excp_code = `CAUSE_INST_MISAL;
    if (excp_info.inst_misal)      excp_code = `CAUSE_INST_MISAL;
    else if (excp_info.inst_acc)   excp_code = `CAUSE_INST_ACC;
    else if (excp_info.ilg_inst)   excp_code = `CAUSE_ILG_INST;
    else if (excp_info.brk_pt)     excp_code = `CAUSE_BRK_PT;
    else if (excp_info.load_misal) excp_code = `CAUSE_LOAD_MISAL;
    else if (excp_info.load_acc)   excp_code = `CAUSE_LOAD_ACC;
    else if (excp_info.stor_misal) excp_code = `CAUSE_STOR_MISAL;
    else if (excp_info.stor_acc)   excp_code = `CAUSE_STOR_ACC;
    else if (excp_info.ecall_m)    excp_code = `CAUSE_ECALL_M;
    else if (excp_info.inst_page)  excp_code = `CAUSE_INST_PAGE;
    else if (excp_info.load_page)  excp_code = `CAUSE_LOAD_PAGE;
    else if (excp_info.stor_page)  excp_code = `CAUSE_STOR_PAGE;
  end

  assign cause_code = itrp_valid ? itrp_code : excp_code;

  // trap value follows the winning exception only
  always_comb begin
    tval = '0;
    if (!itrp_valid) begin
      case (excp_code)
        `CAUSE_INST_MISAL, `CAUSE_INST_ACC, `CAUSE_INST_PAGE:
          tval = now_pc;
        `CAUSE_ILG_INST:
          tval = {{(`XLEN-32){1'b0}}, now_inst};
        `CAUSE_LOAD_MISAL, `CAUSE_LOAD_ACC, `CAUSE_LOAD_PAGE,
        `CAUSE_STOR_MISAL, `CAUSE_STOR_ACC, `CAUSE_STOR_PAGE:
          tval = mem_addr;
        default:
          tval = '0;
      endcase
    end
  end

  // MPIE/MIE shuffle on entry and mret
  always_comb begin
    mstatus_nxt = csr_rd.mstatus;
    if (trap_enter) begin
      mstatus_nxt[`MSTATUS_MPIE] = csr_rd.mstatus[`MSTATUS_MIE];
      mstatus_nxt[`MSTATUS_MIE]  = 1'b0;
    end else if (excp_exit) begin
      mstatus_nxt[`MSTATUS_MIE]  = csr_rd.mstatus[`MSTATUS_MPIE];
      mstatus_nxt[`MSTATUS_MPIE] = 1'b1;
    end
  end

  // software-visible mip bits outside the interrupt lines carry over
  assign csr_wr.mip        = csr_rd.mip & ~`IRQ_MASK;
  assign csr_wr.mcause     = {itrp_valid, {(`XLEN-5){1'b0}}, cause_code};
  assign csr_wr.mepc       = now_pc;
  assign csr_wr.mtval      = tval;
  assign csr_wr.mstatus    = mstatus_nxt;
  assign csr_wr.trap_enter = trap_enter;
  assign csr_wr.trap_exit  = excp_exit & ~trap_enter;

  assign tvec_mode = csr_rd.mtvec[1:0];
  assign tvec_base = {csr_rd.mtvec[`XLEN-1:2], 2'b00};

  // vectored mode offsets interrupts only
  assign enter_pc = (tvec_mode == 2'd1 && itrp_valid) ?
                    tvec_base + {{(`XLEN-6){1'b0}}, cause_code, 2'b00} : tvec_base;

  assign excp_jmp_ena = trap_enter | excp_exit;
  assign excp_jmp_pc  = trap_enter ? enter_pc :
                        excp_exit  ? csr_rd.mepc : '0;

  // core never retires mret on a faulting instruction
  always_comb begin
    mret_no_fault: assert final (!(excp_exit && excp_any))
      else $error("mret together with exception flags %b", excp_info);
  end

endmodule

/* design/trap_top.sv */
// trap_top: CLINT timer, machine CSR file and trap handler of the machine-mode trap unit
`include "trap_defs.svh"

module trap_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ext_irq,
  input  trap_pkg::excp_vec_t  excp_info,
  input  logic [`XLEN-1:0]     now_pc,
  input  logic [31:0]          now_inst,
  input  logic [`XLEN-1:0]     mem_addr,
  input  logic                 excp_exit,
  input  logic                 csr_en,
  input  trap_pkg::csr_op_e    csr_op,
  input  logic [11:0]          csr_addr,
  input  logic [`XLEN-1:0]     csr_wdata,
  output logic [`XLEN-1:0]     csr_rdata,
  input  logic                 clint_we,
  input  trap_pkg::clint_reg_e clint_sel,
  input  logic [`XLEN-1:0]     clint_wdata,
  output logic [`XLEN-1:0]     mtime,
  output logic                 itrp_valid,
  output logic                 excp_jmp_ena,
  output logic [`XLEN-1:0]     excp_jmp_pc
);
  import trap_pkg::*;

  logic        timer_irq;
  logic        soft_irq;
  itrp_vec_t   itrp_lines;
  csr_rd_bus_t csr_rd;
  csr_wr_bus_t csr_wr;

  clint_timer i_clint_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .clint_we    (clint_we),
    .clint_sel   (clint_sel),
    .clint_wdata (clint_wdata),
    .timer_irq   (timer_irq),
    .soft_irq    (soft_irq),
    .mtime       (mtime)
  );

  // external line joins the timer outputs here
  assign itrp_lines.ext_irq   = ext_irq;
  assign itrp_lines.timer_irq = timer_irq;
  assign itrp_lines.soft_irq  = soft_irq;

  machine_csrs i_machine_csrs (
    .clk        (clk),
    .rst_n      (rst_n),
    .itrp_lines (itrp_lines),
    .csr_wr     (csr_wr),
    .csr_en     (csr_en),
    .csr_op     (csr_op),
    .csr_addr   (csr_addr),
    .csr_wdata  (csr_wdata),
    .csr_rd     (csr_rd),
    .csr_rdata  (csr_rdata)
  );

  trap_handler i_trap_handler (
    .excp_info    (excp_info),
    .now_pc       (now_pc),
    .now_inst     (now_inst),
    .mem_addr     (mem_addr),
    .excp_exit    (excp_exit),
    .csr_rd       (csr_rd),
    .csr_wr       (csr_wr),
    .itrp_valid   (itrp_valid),
    .excp_jmp_ena (excp_jmp_ena),
    .excp_jmp_pc  (excp_jmp_pc)
  );

endmodule

/* tb/trap_tb.sv */
// trap_tb: clock, reset, stimulus tasks, reference model and checking assertions for trap_top
`include "trap_defs.svh"

module trap_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import trap_pkg::*;

  localparam int MAX_CYCLES = 2000;

  logic             clk;
  logic             rst_n;
  logic             ext_irq;
  excp_vec_t        excp_info;
  logic [`XLEN-1:0] now_pc;
  logic [31:0]      now_inst;
  logic [`XLEN-1:0] mem_addr;
  logic             excp_exit;
  logic             csr_en;
  csr_op_e          csr_op;
  logic [11:0]      csr_addr;
  logic [`XLEN-1:0] csr_wdata;
  logic [`XLEN-1:0] csr_rdata;
  logic             clint_we;
  clint_reg_e       clint_sel;
  logic [`XLEN-1:0] clint_wdata;
  logic [`XLEN-1:0] mtime;
  logic             itrp_valid;
  logic             excp_jmp_ena;
  logic [`XLEN-1:0] excp_jmp_pc;
  int               cycle_count;

  // reference model state
  logic [`XLEN-1:0] m_mstatus;
  logic [`XLEN-1:0] m_mie;
  logic [`XLEN-1:0] m_mip;
  logic [`XLEN-1:0] m_mtvec;
  logic [`XLEN-1:0] m_mepc;
  logic [`XLEN-1:0] m_mcause;
  logic [`XLEN-1:0] m_mtval;
  logic [`XLEN-1:0] m_mtime;
  logic [`XLEN-1:0] m_mtimecmp;
  logic             m_msip;

  // reference model results
  logic [`XLEN-1:0] m_lines;
  logic [`XLEN-1:0] m_pend;
  logic [`XLEN-1:0] m_base;
  logic [`XLEN-1:0] m_sw_val;
  logic [`XLEN-1:0] exp_pc;
  logic [`XLEN-1:0] exp_tval;
  logic [`XLEN-1:0] exp_rdata;
  logic [3:0]       exp_code;
  logic             exp_itrp;
  logic             exp_enter;
  logic             exp_ena;

  trap_top i_dut (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // fault flag position to exception code
  function automatic logic [3:0] flag_code(int idx);
    case (idx)
      8:       flag_code = `CAUSE_ECALL_M;
      9:       flag_code = `CAUSE_INST_PAGE;
      10:      flag_code = `CAUSE_LOAD_PAGE;
      11:      flag_code = `CAUSE_STOR_PAGE;
      default: flag_code = idx[3:0];
    endcase
  endfunction

  function automatic logic [3:0] lowest_cause(excp_vec_t flags);
    logic [11:0] bits;
    logic [3:0]  code;
    bits = flags;
    code = 4'd0;
    for (int i = 11; i >= 0; i--) begin
      if (bits[i]) code = flag_code(i);
    end
    return code;
  endfunction

  function automatic logic [`XLEN-1:0] tval_source(logic [3:0] code, logic [`XLEN-1:0] pc,
                                                   logic [31:0] inst, logic [`XLEN-1:0] addr);
    case (code)
      `CAUSE_INST_MISAL, `CAUSE_INST_ACC, `CAUSE_INST_PAGE: return pc;
      `CAUSE_ILG_INST: return {32'd0, inst};
      `CAUSE_LOAD_MISAL, `CAUSE_LOAD_ACC, `CAUSE_LOAD_PAGE,
      `CAUSE_STOR_MISAL, `CAUSE_STOR_ACC, `CAUSE_STOR_PAGE: return addr;
      default: return '0;
    endcase
  endfunction

  // expected handler outputs and read data from the model state
  always_comb begin
    m_lines = '0;
    m_lines[`CAUSE_MEI] = ext_irq;
    m_lines[`CAUSE_MTI] = (m_mtime >= m_mtimecmp);
    m_lines[`CAUSE_MSI] = m_msip;
    m_pend = m_mstatus[`MSTATUS_MIE] ? (m_mie & m_mip) : '0;
    exp_itrp = |m_pend;
    if (m_pend[`CAUSE_MEI]) exp_code = `CAUSE_MEI;
    else if (m_pend[`CAUSE_MSI]) exp_code = `CAUSE_MSI;
    else if (m_pend[`CAUSE_MTI]) exp_code = `CAUSE_MTI;
    else exp_code = lowest_cause(excp_info);
    exp_enter = exp_itrp | (|excp_info);
    exp_ena = exp_enter | excp_exit;
    exp_tval = exp_itrp ? '0 : tval_source(exp_code, now_pc, now_inst, mem_addr);
    m_base = {m_mtvec[`XLEN-1:2], 2'b00};
    if (exp_enter && m_mtvec[1:0] == 2'd1 && exp_itrp) exp_pc = m_base + (`XLEN'(exp_code) << 2);
    else if (exp_enter) exp_pc = m_base;
    else if (excp_exit) exp_pc = m_mepc;
    else exp_pc = '0;
    case (csr_addr)
      `CSR_MSTATUS: exp_rdata = m_mstatus;
      `CSR_MIE:     exp_rdata = m_mie;
      `CSR_MIP:     exp_rdata = m_mip;
      `CSR_MTVEC:   exp_rdata = m_mtvec;
      `CSR_MEPC:    exp_rdata = m_mepc;
      `CSR_MCAUSE:  exp_rdata = m_mcause;
      `CSR_MTVAL:   exp_rdata = m_mtval;
      default:      exp_rdata = '0;
    endcase
    case (csr_op)
      CSR_SET:   m_sw_val = exp_rdata | csr_wdata;
      CSR_CLEAR: m_sw_val = exp_rdata & ~csr_wdata;
      default:   m_sw_val = csr_wdata;
    endcase
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      m_mstatus  <= '0;
      m_mie      <= '0;
      m_mip      <= '0;
      m_mtvec    <= '0;
      m_mepc     <= '0;
      m_mcause   <= '0;
      m_mtval    <= '0;
      m_mtime    <= '0;
      m_mtimecmp <= '1;
      m_msip     <= 1'b0;
    end else begin
      m_mtime <= m_mtime + 64'd1;
      m_mip   <= m_lines;
      if (clint_we && clint_sel == CLINT_MTIMECMP) m_mtimecmp <= clint_wdata;
      if (clint_we && clint_sel == CLINT_MSIP) m_msip <= clint_wdata[0];
      if (csr_en) begin
        case (csr_addr)
          `CSR_MSTATUS: m_mstatus <= m_sw_val;
          `CSR_MIE:     m_mie     <= m_sw_val & `IRQ_MASK;
          `CSR_MTVEC:   m_mtvec   <= (m_sw_val[1:0] > 2'd1) ? (m_sw_val & ~64'd3) : m_sw_val;
          `CSR_MEPC:    m_mepc    <= m_sw_val;
          `CSR_MCAUSE:  m_mcause  <= m_sw_val;
          `CSR_MTVAL:   m_mtval   <= m_sw_val;
          default: ;
        endcase
      end
      if (exp_enter) begin
        m_mcause  <= {exp_itrp, 59'd0, exp_code};
        m_mepc    <= now_pc;
        m_mtval   <= exp_tval;
        m_mstatus <= (m_mstatus & ~64'h88) | (`XLEN'(m_mstatus[`MSTATUS_MIE]) << `MSTATUS_MPIE);
      end else if (excp_exit) begin
        m_mstatus <= (m_mstatus & ~64'h8) | 64'h80 |
                     (`XLEN'(m_mstatus[`MSTATUS_MPIE]) << `MSTATUS_MIE);
      end
    end
  end

  task automatic report_mismatch(string name, logic [`XLEN-1:0] got, logic [`XLEN-1:0] want);
    $display("[FAIL] t=%0t %s: dut=%h model=%h", $time, name, got, want);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s differs from the reference model", name);
  endtask

  jmp_ena_matches: assert property (@(posedge clk) disable iff (!rst_n)
    excp_jmp_ena == exp_ena)
    else report_mismatch("excp_jmp_ena", `XLEN'($sampled(excp_jmp_ena)), `XLEN'($sampled(exp_ena)));

  jmp_pc_matches: assert property (@(posedge clk) disable iff (!rst_n)
    exp_ena |-> excp_jmp_pc == exp_pc)
    else report_mismatch("excp_jmp_pc", $sampled(excp_jmp_pc), $sampled(exp_pc));

  itrp_matches: assert property (@(posedge clk) disable iff (!rst_n)
    itrp_valid == exp_itrp)
    else report_mismatch("itrp_valid", `XLEN'($sampled(itrp_valid)), `XLEN'($sampled(exp_itrp)));

  rdata_matches: assert property (@(posedge clk) disable iff (!rst_n)
    csr_rdata == exp_rdata)
    else report_mismatch("csr_rdata", $sampled(csr_rdata), $sampled(exp_rdata));

  mtime_matches: assert property (@(posedge clk) disable iff (!rst_n)
    mtime == m_mtime)
    else report_mismatch("mtime", $sampled(mtime), $sampled(m_mtime));

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "cycle limit reached");
    end
  end

  // strobes last one cycle, addresses and data stay put
  task automatic next_cycle();
    @(posedge clk);
    #10;
    excp_info = '0;
    excp_exit = 1'b0;
    csr_en    = 1'b0;
    clint_we  = 1'b0;
  endtask

  task automatic csr_access(csr_op_e op, logic [11:0] addr, logic [`XLEN-1:0] data);
    next_cycle();
    csr_en    = 1'b1;
    csr_op    = op;
    csr_addr  = addr;
    csr_wdata = data;
  endtask

  task automatic csr_read(logic [11:0] addr);
    next_cycle();
    csr_addr = addr;
  endtask

  task automatic clint_write(clint_reg_e sel, logic [`XLEN-1:0] data);
    next_cycle();
    clint_we    = 1'b1;
    clint_sel   = sel;
    clint_wdata = data;
  endtask

  task automatic raise_fault(logic [11:0] flags);
    next_cycle();
    excp_info = flags;
    now_pc    = {$urandom, $urandom};
    now_inst  = $urandom;
    mem_addr  = {$urandom, $urandom};
  endtask

  task automatic read_trap_csrs();
    csr_read(`CSR_MCAUSE);
    csr_read(`CSR_MEPC);
    csr_read(`CSR_MTVAL);
  endtask

  initial begin
    logic [11:0] flags;
    void'($urandom(32'h3109_9370));
    rst_n       = 1'b0;
    ext_irq     = 1'b0;
    excp_info   = '0;
    now_pc      = '0;
    now_inst    = '0;
    mem_addr    = '0;
    excp_exit   = 1'b0;
    csr_en      = 1'b0;
    csr_op      = CSR_WRITE;
    csr_addr    = '0;
    csr_wdata   = '0;
    clint_we    = 1'b0;
    clint_sel   = CLINT_MTIMECMP;
    clint_wdata = '0;
    cycle_count = 0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;

    // direct mode, one fault at a time
    csr_access(CSR_WRITE, `CSR_MTVEC, 64'h0000_0000_8000_0100);
    csr_access(CSR_WRITE, `CSR_MSTATUS, 64'h80);
    for (int i = 0; i < 12; i++) begin
      raise_fault(12'(1 << i));
      read_trap_csrs();
    end

    // multi-bit faults, every fourth one led by an illegal instruction
    for (int i = 0; i < 120; i++) begin
      flags = 12'($urandom);
      if (i % 4 == 0) flags = (flags & 12'hff8) | 12'h004;
      if (flags == '0) flags = 12'h800;
      raise_fault(flags);
      csr_read(`CSR_MCAUSE);
      csr_read(`CSR_MTVAL);
    end

    // mret restores MIE, then mie set and clear
    csr_access(CSR_WRITE, `CSR_MSTATUS, 64'h8);
    raise_fault(12'h010);
    csr_read(`CSR_MSTATUS);
    next_cycle();
    excp_exit = 1'b1;
    csr_read(`CSR_MSTATUS);
    csr_access(CSR_SET, `CSR_MIE, 64'h888);
    csr_read(`CSR_MIE);
    csr_access(CSR_CLEAR, `CSR_MIE, 64'h808);
    csr_read(`CSR_MIE);
    csr_access(CSR_CLEAR, `CSR_MIE, '1);
    csr_access(CSR_WRITE, `CSR_MTVEC, 64'h0000_0000_8000_0103);
    csr_read(`CSR_MTVEC);

    // vectored timer interrupt
    csr_access(CSR_WRITE, `CSR_MTVEC, 64'h0000_0000_8000_0201);
    csr_access(CSR_WRITE, `CSR_MIE, 64'h80);
    csr_access(CSR_SET, `CSR_MSTATUS, 64'h8);
    clint_write(CLINT_MTIMECMP, mtime + 64'd20);
    while (!itrp_valid)
      next_cycle();
    csr_read(`CSR_MCAUSE);
    csr_read(`CSR_MSTATUS);
    repeat (5) next_cycle();
    clint_write(CLINT_MTIMECMP, '1);

    // software and external pending while masked, then taken with a fault
    csr_access(CSR_WRITE, `CSR_MIE, 64'h888);
    clint_write(CLINT_MSIP, 64'd1);
    ext_irq = 1'b1;
    repeat (4) next_cycle();
    csr_read(`CSR_MIP);
    csr_access(CSR_SET, `CSR_MSTATUS, 64'h8);
    raise_fault(12'h004);
    read_trap_csrs();
    repeat (10) next_cycle();
    ext_irq = 1'b0;
    clint_write(CLINT_MSIP, 64'd0);
    repeat (4) next_cycle();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* list.f */
+incdir+design
design/trap_pkg.sv
design/clint_timer.sv
design/machine_csrs.sv
design/trap_handler.sv
design/trap_top.sv
tb/trap_tb.sv

/* run.sh */
#!/bin/sh
# builds the trap unit testbench with Verilator and runs it
# the exit status is nonzero when the simulation ends in $fatal
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module trap_tb -o trap_sim &&
  ./obj_dir/trap_sim ||
  { echo "simulation failed"; exit 1; }
